/* Bender.yml */
package:
  name: rv64_ex

sources:
  - include_dirs:
      - logic
    files:
      - logic/alu_pkg.sv
      - logic/pipe_pkg.sv
      - logic/ex_decode.sv
      - logic/ex_execute.sv
      - logic/ex_result.sv
      - logic/ex_stage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/ex_stage_props.sv
      - verif/ex_stage_tb.sv

/* logic/alu_pkg.sv */
`include "rv64_ex_config.svh"

package alu_pkg;

	typedef enum logic [`RV64_ALU_OP_W-1:0] {
		alu_add  = 'd0,
		alu_addw = 'd1,
		alu_sll  = 'd2,
		alu_sllw = 'd3,
		alu_sra  = 'd4,
		alu_sraw = 'd5,
		alu_srl  = 'd6,
		alu_srlw = 'd7,
		alu_and  = 'd8,
		alu_or   = 'd9,
		alu_xor  = 'd10,
		alu_slt  = 'd11, // signed less than
		alu_sltu = 'd12,
		alu_eq   = 'd13,
		alu_ne   = 'd14,
		alu_sge  = 'd15,
		alu_sgeu = 'd16,
		alu_sub  = 'd17,
		alu_subw = 'd18  // 19..31 illegal
	} alu_op_e;

	typedef enum logic [3:0] {
		unit_add,
		unit_sub,
		unit_shl,
		unit_shr_arith,
		unit_shr_logic,
		unit_and,
		unit_or,
		unit_xor,
		unit_cmp,
		unit_none // result forced to zero
	} alu_unit_e;

	typedef enum logic [2:0] {
		cmp_lt_s,
		cmp_lt_u,
		cmp_ge_s,
		cmp_ge_u,
		cmp_eq,
		cmp_ne
	} cmp_kind_e;

	typedef struct packed {
		alu_unit_e unit;
		cmp_kind_e cmp;  // only meaningful for unit_cmp
		logic      word; // 32-bit op, sign-extend bit 31
	} alu_ctrl_t;

endpackage

/* logic/ex_decode.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_decode
	import alu_pkg::*;
(
	input  alu_op_e   alu_op,
	output alu_ctrl_t alu_ctrl
);

	// illegal codes fall through to this
	localparam alu_ctrl_t CTRL_NONE = '{unit: unit_none, cmp: cmp_eq, word: 1'b0};

	always_comb begin
		case (alu_op)
			alu_add:
				alu_ctrl = '{unit: unit_add, cmp: cmp_eq, word: 1'b0};
			alu_addw:
				alu_ctrl = '{unit: unit_add, cmp: cmp_eq, word: 1'b1};
			alu_sll:
				alu_ctrl = '{unit: unit_shl, cmp: cmp_eq, word: 1'b0};
			alu_sllw:
				alu_ctrl = '{unit: unit_shl, cmp: cmp_eq, word: 1'b1};
			alu_sra:
				alu_ctrl = '{unit: unit_shr_arith, cmp: cmp_eq, word: 1'b0};
			alu_sraw:
				alu_ctrl = '{unit: unit_shr_arith, cmp: cmp_eq, word: 1'b1};
			alu_srl:
				alu_ctrl = '{unit: unit_shr_logic, cmp: cmp_eq, word: 1'b0};
			alu_srlw:
				alu_ctrl = '{unit: unit_shr_logic, cmp: cmp_eq, word: 1'b1};
			alu_and:
				alu_ctrl = '{unit: unit_and, cmp: cmp_eq, word: 1'b0};
			alu_or:
				alu_ctrl = '{unit: unit_or, cmp: cmp_eq, word: 1'b0};
			alu_xor:
				alu_ctrl = '{unit: unit_xor, cmp: cmp_eq, word: 1'b0};
			alu_slt:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_lt_s, word: 1'b0};
			alu_sltu:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_lt_u, word: 1'b0};
			alu_eq:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_eq, word: 1'b0};
			alu_ne:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_ne, word: 1'b0};
			alu_sge:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_ge_s, word: 1'b0};
			alu_sgeu:
				alu_ctrl = '{unit: unit_cmp, cmp: cmp_ge_u, word: 1'b0};
			alu_sub:
				alu_ctrl = '{unit: unit_sub, cmp: cmp_eq, word: 1'b0};
			alu_subw:
				alu_ctrl = '{unit: unit_sub, cmp: cmp_eq, word: 1'b1}; // signed 32-bit sub
			default:
				alu_ctrl = CTRL_NONE;
		endcase
	end

endmodule

/* logic/ex_execute.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_execute
	import alu_pkg::*;
	import pipe_pkg::*;
(
	input  alu_ctrl_t               alu_ctrl,
	input  logic [`RV64_XLEN-1:0]   src_a,
	input  logic [`RV64_XLEN-1:0]   src_b,
	input  logic [`RV64_XLEN-1:0]   pc,
	input  logic [`RV64_BIMM_W-1:0] b_imm,
	input  logic                    branch,
	output logic [`RV64_XLEN-1:0]   alu_result,
	output br_t                     br
);

	localparam int BIMM_EXT = `RV64_XLEN - `RV64_BIMM_W - 1;

	logic [5:0]            shamt_d; // 64-bit shift amount
	logic [4:0]            shamt_w;
	logic [31:0]           a_w;
	logic [31:0]           b_w;
	logic                  lt_s;
	logic                  lt_u;
	logic                  eq;
	logic                  cmp_bit;
	logic [`RV64_XLEN-1:0] wide;
	logic [31:0]           narrow;
	logic [`RV64_XLEN-1:0] b_off;

	assign shamt_d = src_b[5:0];
	assign shamt_w = src_b[4:0];
	assign a_w     = src_a[31:0];
	assign b_w     = src_b[31:0];

	assign lt_s = $signed(src_a) < $signed(src_b);
	assign lt_u = src_a < src_b;
	assign eq   = src_a == src_b;

	always_comb begin
		case (alu_ctrl.cmp)
			cmp_lt_s: cmp_bit = lt_s;
			cmp_lt_u: cmp_bit = lt_u;
			cmp_ge_s: cmp_bit = ~lt_s;
			cmp_ge_u: cmp_bit = ~lt_u;
			cmp_eq:   cmp_bit = eq;
			cmp_ne:   cmp_bit = ~eq;
			default:  cmp_bit = 1'b0;
		endcase
	end

	// wide is the 64-bit form, narrow the word form of the same unit
	always_comb begin
		wide   = '0;
		narrow = '0;
		case (alu_ctrl.unit)
			unit_add: begin
				wide   = src_a + src_b;
				narrow = a_w + b_w;
			end
			unit_sub: begin
				wide   = src_a - src_b;
				narrow = a_w - b_w;
			end
			unit_shl: begin
				wide   = src_a << shamt_d;
				narrow = a_w << shamt_w;
			end
			unit_shr_arith: begin
				wide   = $signed(src_a) >>> shamt_d;
				narrow = $signed(a_w) >>> shamt_w;
			end
			unit_shr_logic: begin
				wide   = src_a >> shamt_d;
				narrow = a_w >> shamt_w;
			end
			unit_and: wide = src_a & src_b;
			unit_or:  wide = src_a | src_b;
			unit_xor: wide = src_a ^ src_b;
			unit_cmp: wide = {{(`RV64_XLEN-1){1'b0}}, cmp_bit};
			default: begin
				wide   = '0; // unit_none
				narrow = '0;
			end
		endcase
	end

	assign alu_result = alu_ctrl.word ? {{32{narrow[31]}}, narrow} : wide;

	// B immediate is in halfwords
	assign b_off = {{BIMM_EXT{b_imm[`RV64_BIMM_W-1]}}, b_imm, 1'b0};

	assign br.target = pc + b_off;
	assign br.taken  = branch & (|alu_result);

endmodule

/* logic/ex_result.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_result
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  valid_in,
	input  logic                  ready_out,
	input  ex_in_t                stage_in,
	input  logic [`RV64_XLEN-1:0] alu_result,
	output logic                  ready_in,
	output logic                  valid_out,
	output logic                  bubble,
	output ex_out_t               ex_out
);

	logic accept;
	logic is_branch;

	assign accept    = valid_in & ready_out;
	assign is_branch = stage_in.ins[`RV64_OPCODE_W-1:0] == `RV64_OPC_BRANCH;

	assign ready_in = ready_out; // single-cycle alu, never stalls itself
	assign bubble   = accept & is_branch;

	// valid tracks input whenever downstream takes data
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (ready_out) begin
			valid_out <= valid_in;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_out <= '0;
		end else if (accept) begin
			ex_out.pc         <= stage_in.pc;
			ex_out.ins        <= stage_in.ins;
			ex_out.mem_w_en   <= stage_in.mem_w_en;
			ex_out.wb_sel     <= stage_in.wb_sel;
			ex_out.reg_w_en   <= stage_in.reg_w_en;
			ex_out.rt_data    <= stage_in.rt_data;
			ex_out.rd         <= stage_in.rd;
			ex_out.alu_result <= alu_result;
		end
	end

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_stage
	import alu_pkg::*;
	import pipe_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  ex_in_t                ex_in,
	input  alu_op_e               alu_op,
	input  logic [`RV64_XLEN-1:0] src_a,
	input  logic [`RV64_XLEN-1:0] src_b,
	input  logic                  valid_in,  // from decode
	input  logic                  ready_out, // from memory stage
	output logic                  ready_in,
	output logic                  valid_out,
	output ex_out_t               ex_out,
	output fwd_t                  fwd,
	output br_t                   br,
	output logic                  bubble
);

	alu_ctrl_t             alu_ctrl;
	logic [`RV64_XLEN-1:0] alu_result;

	ex_decode i_ex_decode (
		.alu_op   (alu_op),
		.alu_ctrl (alu_ctrl)
	);

	ex_execute i_ex_execute (
		.alu_ctrl   (alu_ctrl),
		.src_a      (src_a),
		.src_b      (src_b),
		.pc         (ex_in.pc),
		.b_imm      (ex_in.b_imm),
		.branch     (ex_in.branch),
		.alu_result (alu_result),
		.br         (br)
	);

	ex_result i_ex_result (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.ready_out  (ready_out),
		.stage_in   (ex_in),
		.alu_result (alu_result),
		.ready_in   (ready_in),
		.valid_out  (valid_out),
		.bubble     (bubble),
		.ex_out     (ex_out)
	);

	// same-cycle bypass towards decode
	assign fwd = '{
		reg_w_en: ex_in.reg_w_en,
		rd:       ex_in.rd,
		value:    alu_result
	};

endmodule

/* logic/pipe_pkg.sv */
`include "rv64_ex_config.svh"

package pipe_pkg;

	// what decode hands to execute
	typedef struct packed {
		logic [`RV64_XLEN-1:0]   pc;
		logic [`RV64_ILEN-1:0]   ins;
		logic                    branch;
		logic                    mem_w_en;
		logic                    wb_sel; // 0 alu result, 1 memory data
		logic                    reg_w_en;
		logic [`RV64_REG_AW-1:0] rd;
		logic [`RV64_XLEN-1:0]   rt_data; // store data
		logic [`RV64_BIMM_W-1:0] b_imm;
	} ex_in_t;

	// register towards memory stage
	typedef struct packed {
		logic [`RV64_XLEN-1:0]   pc;
		logic [`RV64_ILEN-1:0]   ins;
		logic                    mem_w_en;
		logic                    wb_sel;
		logic                    reg_w_en;
		logic [`RV64_XLEN-1:0]   rt_data;
		logic [`RV64_REG_AW-1:0] rd;
		logic [`RV64_XLEN-1:0]   alu_result;
	} ex_out_t;

	typedef struct packed {
		logic                    reg_w_en;
		logic [`RV64_REG_AW-1:0] rd;
		logic [`RV64_XLEN-1:0]   value;
	} fwd_t;

	typedef struct packed {
		logic                  taken;
		logic [`RV64_XLEN-1:0] target;
	} br_t;

endpackage

/* logic/rv64_ex_config.svh */
`ifndef RV64_EX_CONFIG_SVH
`define RV64_EX_CONFIG_SVH

// datapath and address width
`define RV64_XLEN 64

`define RV64_ILEN 32

`define RV64_REG_AW 5

`define RV64_ALU_OP_W 5

// B immediate bits 12..1
`define RV64_BIMM_W 12

`define RV64_OPCODE_W 7

`define RV64_OPC_BRANCH 7'b110_0011

`endif

/* rv64_ex.f */
+incdir+logic
logic/alu_pkg.sv
logic/pipe_pkg.sv
logic/ex_decode.sv
logic/ex_execute.sv
logic/ex_result.sv
logic/ex_stage.sv
verif/ex_stage_props.sv
verif/ex_stage_tb.sv

/* verif/ex_stage_props.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_result_props
	import pipe_pkg::*;
(
	input logic    clk,
	input logic    reset,
	input logic    valid_in,
	input logic    ready_out,
	input logic    valid_out,
	input logic    bubble,
	input ex_out_t ex_out
);

	int unsigned fail_count = 0;

	a_reset_clears_valid: assert property (@(posedge clk) reset |=> !valid_out)
		else begin
			$error("valid_out not cleared by reset");
			fail_count++;
		end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		!ready_out |=> $stable(ex_out) && $stable(valid_out))
		else begin
			$error("ex_out or valid_out changed while ready_out low");
			fail_count++;
		end

	a_valid_follows_input: assert property (@(posedge clk) disable iff (reset)
		ready_out |=> valid_out == $past(valid_in))
		else begin
			$error("valid_out did not load valid_in while ready_out high");
			fail_count++;
		end

	a_bubble_on_accept: assert property (@(posedge clk) disable iff (reset)
		bubble |=> valid_out && ex_out.ins[`RV64_OPCODE_W-1:0] == `RV64_OPC_BRANCH)
		else begin
			$error("bubble without an accepted branch");
			fail_count++;
		end

endmodule

bind ex_result ex_result_props i_ex_result_props (
	.clk       (clk),
	.reset     (reset),
	.valid_in  (valid_in),
	.ready_out (ready_out),
	.valid_out (valid_out),
	.bubble    (bubble),
	.ex_out    (ex_out)
);

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "rv64_ex_config.svh"

module ex_stage_tb
	import alu_pkg::*;
	import pipe_pkg::*;
();

	localparam logic [31:0]                SEED   = 32'hc85d_6617;
	localparam logic [`RV64_OPCODE_W-1:0] OPC_OP = 7'b011_0011;
	localparam logic [`RV64_XLEN-1:0]     PC0    = 64'h1000;

	typedef struct packed {
		logic [`RV64_ALU_OP_W-1:0] op;
		logic [`RV64_XLEN-1:0]     a;
		logic [`RV64_XLEN-1:0]     b;
		logic [`RV64_XLEN-1:0]     res;
		logic                      rdy;
		logic                      vld;
		logic                      br_f;
		logic [`RV64_OPCODE_W-1:0] opc;
		logic [`RV64_BIMM_W-1:0]   imm;
		logic [`RV64_XLEN-1:0]     pc;
		logic                      taken;
		logic [`RV64_XLEN-1:0]     tgt;
	} row_t;

	logic                  clk;
	logic                  reset;
	ex_in_t                ex_in;
	alu_op_e               alu_op;
	logic [`RV64_XLEN-1:0] src_a;
	logic [`RV64_XLEN-1:0] src_b;
	logic                  valid_in;
	logic                  ready_out;
	logic                  ready_in;
	logic                  valid_out;
	ex_out_t               ex_out;
	fwd_t                  fwd;
	br_t                   br;
	logic                  bubble;

	row_t                                 rows[$];
	ex_out_t                              exp_out;
	logic                                 exp_valid;
	logic                                 hold; // upstream keeps its item while stalled
	logic [`RV64_ILEN-`RV64_OPCODE_W-1:0] ins_hi;
	int unsigned                          errors      = 0;
	int unsigned                          checks      = 0;
	int unsigned                          cycles      = 0;
	int unsigned                          cycle_limit = 20;

	ex_stage i_ex_stage (
		.clk       (clk),
		.reset     (reset),
		.ex_in     (ex_in),
		.alu_op    (alu_op),
		.src_a     (src_a),
		.src_b     (src_b),
		.valid_in  (valid_in),
		.ready_out (ready_out),
		.ready_in  (ready_in),
		.valid_out (valid_out),
		.ex_out    (ex_out),
		.fwd       (fwd),
		.br        (br),
		.bubble    (bubble)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the stimulus table did not finish", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_row(input logic [`RV64_ALU_OP_W-1:0] op,
		input logic [`RV64_XLEN-1:0] a, input logic [`RV64_XLEN-1:0] b,
		input logic [`RV64_XLEN-1:0] res, input logic rdy = 1'b1, input logic vld = 1'b1,
		input logic br_f = 1'b0, input logic [`RV64_OPCODE_W-1:0] opc = OPC_OP,
		input logic [`RV64_BIMM_W-1:0] imm = '0, input logic [`RV64_XLEN-1:0] pc = PC0,
		input logic taken = 1'b0, input logic [`RV64_XLEN-1:0] tgt = PC0);
		row_t r;
		r = '{op, a, b, res, rdy, vld, br_f, opc, imm, pc, taken, tgt};
		rows.push_back(r);
	endtask

	task automatic fill_table();
		add_row(alu_add, 64'h01234567_89abcdef, 64'h11111111_11111111,
			64'h12345678_9abcdf00);
		add_row(alu_addw, 64'h12345678_7fffffff, 64'h1, 64'hffffffff_80000000);
		add_row(alu_sll, 64'h1, 64'h43, 64'h8); // 67 masked to 3
		add_row(alu_sllw, 64'h3, 64'h3e, 64'hffffffff_c0000000); // 62 masked to 30
		add_row(alu_sra, 64'h80000000_00000000, 64'h4, 64'hf8000000_00000000);
		add_row(alu_sraw, 64'h00000000_80000010, 64'h24, 64'hffffffff_f8000001);
		add_row(alu_srl, 64'hf0000000_00000000, 64'h44, 64'h0f000000_00000000);
		add_row(alu_srlw, 64'h00000000_80000000, 64'h20, 64'hffffffff_80000000);
		add_row(alu_and, 64'hff00ff00_ff00ff00, 64'h0ff00ff0_0ff00ff0,
			64'h0f000f00_0f000f00);
		add_row(alu_or, 64'hff00ff00_ff00ff00, 64'h0ff00ff0_0ff00ff0,
			64'hfff0fff0_fff0fff0);
		add_row(alu_xor, 64'hff00ff00_ff00ff00, 64'h0ff00ff0_0ff00ff0,
			64'hf0f0f0f0_f0f0f0f0);
		add_row(alu_slt, 64'hffffffff_ffffffff, 64'h1, 64'h1);
		add_row(alu_sltu, 64'hffffffff_ffffffff, 64'h1, 64'h0);
		add_row(alu_eq, 64'h5, 64'h5, 64'h1);
		add_row(alu_ne, 64'h5, 64'h5, 64'h0);
		add_row(alu_sge, 64'h1, 64'hffffffff_ffffffff, 64'h1);
		add_row(alu_sgeu, 64'hffffffff_ffffffff, 64'h1, 64'h1);
		add_row(alu_sub, 64'h0, 64'h1, 64'hffffffff_ffffffff);
		add_row(alu_subw, 64'h00000001_00000000, 64'h1, 64'hffffffff_ffffffff);
		add_row(5'd19, 64'h5, 64'h5, 64'h0); // illegal
		add_row(5'd31, 64'hffffffff_ffffffff, 64'h1, 64'h0);
		add_row(alu_ne, 64'h1, 64'h2, 64'h1, 1'b1, 1'b1, 1'b1, `RV64_OPC_BRANCH, 12'h010,
			64'h2000, 1'b1, 64'h2020);
		add_row(alu_eq, 64'h1, 64'h2, 64'h0, 1'b1, 1'b1, 1'b1, `RV64_OPC_BRANCH, 12'hffe,
			64'h2000, 1'b0, 64'h1ffc); // backward, not taken
		add_row(alu_sltu, 64'h1, 64'h2, 64'h1, 1'b1, 1'b1, 1'b1, OPC_OP, 12'h001,
			64'h100, 1'b1, 64'h102);
		add_row(alu_eq, 64'h3, 64'h3, 64'h1, 1'b1, 1'b0, 1'b1, `RV64_OPC_BRANCH, 12'h800,
			64'h3000, 1'b1, 64'h2000); // no valid, no bubble
		repeat (2) begin
			add_row(alu_ne, 64'h10, 64'h20, 64'h1, 1'b0, 1'b1, 1'b1, `RV64_OPC_BRANCH,
				12'h004, 64'h4000, 1'b1, 64'h4008); // stalled
		end
		add_row(alu_ne, 64'h10, 64'h20, 64'h1, 1'b1, 1'b1, 1'b1, `RV64_OPC_BRANCH,
			12'h004, 64'h4000, 1'b1, 64'h4008);
		add_row(alu_add, 64'h7, 64'h8, 64'hf);
	endtask

	task automatic check_registers();
		check_value("valid_out", valid_out, exp_valid);
		check_value("ex_out", ex_out, exp_out);
		check_value("ex_out.alu_result", ex_out.alu_result, exp_out.alu_result);
		check_value("ex_out.pc", ex_out.pc, exp_out.pc);
		check_value("ex_out.ins", ex_out.ins, exp_out.ins);
		check_value("ex_out.rd", ex_out.rd, exp_out.rd);
		check_value("ex_out.rt_data", ex_out.rt_data, exp_out.rt_data);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] rnd_a;
		logic [31:0] rnd_b;
		logic        acc;
		acc = r.vld & r.rdy;
		if (!hold) begin
			rnd_a = $urandom;
			rnd_b = $urandom;
			ex_in.rt_data = {rnd_a, rnd_b};
			rnd_a = $urandom;
			ex_in.rd       = rnd_a[4:0];
			ex_in.reg_w_en = rnd_a[5];
			ex_in.mem_w_en = rnd_a[6];
			ex_in.wb_sel   = rnd_a[7];
			ins_hi         = rnd_a[31:7];
		end
		ex_in.ins    = {ins_hi, r.opc};
		ex_in.pc     = r.pc;
		ex_in.branch = r.br_f;
		ex_in.b_imm  = r.imm;
		alu_op       = alu_op_e'(r.op);
		src_a        = r.a;
		src_b        = r.b;
		valid_in     = r.vld;
		ready_out    = r.rdy;
		hold         = r.vld & ~r.rdy;
		@(negedge clk);
		check_registers();
		check_value("fwd.value", fwd.value, r.res);
		check_value("fwd.rd", fwd.rd, ex_in.rd);
		check_value("fwd.reg_w_en", fwd.reg_w_en, ex_in.reg_w_en);
		check_value("br.taken", br.taken, r.taken);
		check_value("br.target", br.target, r.tgt);
		check_value("ready_in", ready_in, r.rdy);
		check_value("bubble", bubble, acc && r.opc == `RV64_OPC_BRANCH);
		if (r.rdy)
			exp_valid = r.vld;
		if (acc) begin // register loads at the coming edge
			exp_out.pc         = r.pc;
			exp_out.ins        = ex_in.ins;
			exp_out.mem_w_en   = ex_in.mem_w_en;
			exp_out.wb_sel     = ex_in.wb_sel;
			exp_out.reg_w_en   = ex_in.reg_w_en;
			exp_out.rt_data    = ex_in.rt_data;
			exp_out.rd         = ex_in.rd;
			exp_out.alu_result = r.res;
		end
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		ex_in     = '0;
		alu_op    = alu_add;
		src_a     = '0;
		src_b     = '0;
		valid_in  = 1'b0;
		ready_out = 1'b1;
		hold      = 1'b0;
		ins_hi    = '0;
		exp_out   = '0;
		exp_valid = 1'b0;
		void'($urandom(SEED));
		fill_table();
		cycle_limit = rows.size() * 4 + 20;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
		@(negedge clk);
		check_registers(); // cleared by reset
		@(posedge clk);
		#2;
		foreach (rows[i]) begin
			apply_row(rows[i]);
			@(posedge clk);
			#2;
		end
		valid_in  = 1'b0;
		ready_out = 1'b1;
		@(negedge clk);
		check_registers(); // last accepted item
		errors = errors + i_ex_stage.i_ex_result.i_ex_result_props.fail_count;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
